// ==== rtl/fft2d_pkg.sv ====
package fft2d_pkg;

  // transform geometry
  localparam int N_PT      = 4;            // points per 1-D transform
  localparam int FRAME_LEN = N_PT * N_PT;  // samples per 2-D frame
  localparam int PT_W      = 2;            // index within a row or column
  localparam int FRAME_W   = 4;            // index within a frame

  // radix-4 butterfly with twiddles of +-1 and +-j only,
  // so each stage grows by log2(4) bits and stays exact
  localparam int GROWTH_W  = 2;

  // corner-turn bank life cycle
  typedef enum logic [1:0] {
    BANK_FILL,   // accepting row results
    BANK_FULL,   // all sixteen written, waiting for the reader
    BANK_DRAIN   // being read column by column
  } bank_state_e;

endpackage

// ==== rtl/dft4_stage.sv ====
`timescale 1ns/1ps

module dft4_stage
  import fft2d_pkg::*;
#(
  parameter int IN_W = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            in_valid,
  input  logic signed [IN_W-1:0]          in_re,
  input  logic signed [IN_W-1:0]          in_im,
  output logic                            out_valid,
  output logic signed [IN_W+GROWTH_W-1:0] out_re,
  output logic signed [IN_W+GROWTH_W-1:0] out_im
);

  localparam int OUT_W = IN_W + GROWTH_W;  // full growth, no scaling

  logic [PT_W-1:0]         in_idx;            // position in current group
  logic signed [IN_W-1:0]  coll_re [N_PT-1];  // samples 0..2 of the group
  logic signed [IN_W-1:0]  coll_im [N_PT-1];
  logic signed [OUT_W-1:0] x_re [N_PT];       // whole group, slot 3 is live input
  logic signed [OUT_W-1:0] x_im [N_PT];
  logic signed [OUT_W-1:0] a_re, a_im;        // x0 + x2
  logic signed [OUT_W-1:0] b_re, b_im;        // x0 - x2
  logic signed [OUT_W-1:0] c_re, c_im;        // x1 + x3
  logic signed [OUT_W-1:0] d_re, d_im;        // x1 - x3
  logic signed [OUT_W-1:0] bin_re [N_PT];
  logic signed [OUT_W-1:0] bin_im [N_PT];
  logic signed [OUT_W-1:0] res_re [N_PT];     // result bank, head is next bin
  logic signed [OUT_W-1:0] res_im [N_PT];
  logic [PT_W-1:0]         emit_idx;          // bin currently at the head
  logic                    emit_busy;
  logic                    group_done;

  assign group_done = in_valid && (in_idx == PT_W'(N_PT - 1));  // fourth sample

  always_ff @(posedge clk)
  begin
    if (reset)
      in_idx <= '0;
    else if (in_valid)
      in_idx <= in_idx + 1'b1;  // wraps every group
  end

  // first three samples parked, fourth used straight from the port
  always_ff @(posedge clk)
  begin
    if (in_valid && !group_done)
    begin
      coll_re[in_idx] <= in_re;
      coll_im[in_idx] <= in_im;
    end
  end

  always_comb
  begin
    for (int i = 0; i < N_PT - 1; i++)
    begin
      x_re[i] = OUT_W'(coll_re[i]);  // sign extend to output width
      x_im[i] = OUT_W'(coll_im[i]);
    end
    x_re[N_PT-1] = OUT_W'(in_re);
    x_im[N_PT-1] = OUT_W'(in_im);

    a_re = x_re[0] + x_re[2];
    a_im = x_im[0] + x_im[2];
    b_re = x_re[0] - x_re[2];
    b_im = x_im[0] - x_im[2];
    c_re = x_re[1] + x_re[3];
    c_im = x_im[1] + x_im[3];
    d_re = x_re[1] - x_re[3];
    d_im = x_im[1] - x_im[3];

    // W = -j, so bin 1 takes b - j*d and bin 3 takes b + j*d
    bin_re[0] = a_re + c_re;
    bin_im[0] = a_im + c_im;
    bin_re[1] = b_re + d_im;  // -j*d swaps re/im
    bin_im[1] = b_im - d_re;
    bin_re[2] = a_re - c_re;
    bin_im[2] = a_im - c_im;
    bin_re[3] = b_re - d_im;  // +j*d
    bin_im[3] = b_im + d_re;
  end

  // load on group end, else shift toward the head
  always_ff @(posedge clk)
  begin
    if (group_done)
    begin
      res_re <= bin_re;
      res_im <= bin_im;
    end
    else if (emit_busy)
    begin
      for (int i = 0; i < N_PT - 1; i++)
      begin
        res_re[i] <= res_re[i+1];
        res_im[i] <= res_im[i+1];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      emit_busy <= 1'b0;
      emit_idx  <= '0;
    end
    else if (group_done)
    begin
      emit_busy <= 1'b1;  // new load wins over the last bin of the old one
      emit_idx  <= '0;
    end
    else if (emit_busy)
    begin
      emit_idx <= emit_idx + 1'b1;
      if (emit_idx == PT_W'(N_PT - 1))
        emit_busy <= 1'b0;  // bin 3 leaving now
    end
  end

  assign out_valid = emit_busy;
  assign out_re    = res_re[0];
  assign out_im    = res_im[0];

endmodule

// ==== rtl/corner_turn.sv ====
`timescale 1ns/1ps

module corner_turn
  import fft2d_pkg::*;
#(
  parameter int DATA_W = 18
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr_valid,
  input  logic signed [DATA_W-1:0] wr_re,
  input  logic signed [DATA_W-1:0] wr_im,
  output logic                     rd_valid,
  output logic signed [DATA_W-1:0] rd_re,
  output logic signed [DATA_W-1:0] rd_im
);

  // two banks back to back, bank select is the address msb
  logic signed [DATA_W-1:0] mem_re [2*FRAME_LEN];
  logic signed [DATA_W-1:0] mem_im [2*FRAME_LEN];
  bank_state_e              bank_state [2];

  logic                     wr_bank;   // bank being filled
  logic [FRAME_W-1:0]       wr_ptr;    // row-major, row in upper bits
  logic                     wr_done;   // sixteenth write of a bank
  logic                     rd_bank;   // bank being or next to be drained
  logic [FRAME_W-1:0]       rd_ptr;    // column in upper bits, row in lower
  logic [FRAME_W-1:0]       rd_addr;   // transposed back to row-major
  logic                     rd_busy;
  logic                     rd_done;   // last read of the drain
  logic                     nxt_bank;  // candidate for the next drain

  assign wr_done  = wr_valid && (wr_ptr == FRAME_W'(FRAME_LEN - 1));
  assign rd_busy  = (bank_state[rd_bank] == BANK_DRAIN);
  assign rd_done  = rd_busy && (rd_ptr == FRAME_W'(FRAME_LEN - 1));
  assign nxt_bank = rd_done ? ~rd_bank : rd_bank;  // hand over without a gap
  assign rd_addr  = {rd_ptr[PT_W-1:0], rd_ptr[FRAME_W-1:PT_W]};  // swap row/col

  always_ff @(posedge clk)
  begin
    if (wr_valid)
    begin
      mem_re[{wr_bank, wr_ptr}] <= wr_re;
      mem_im[{wr_bank, wr_ptr}] <= wr_im;
    end
  end

  // registered read port
  always_ff @(posedge clk)
  begin
    if (rd_busy)
    begin
      rd_re <= mem_re[{rd_bank, rd_addr}];
      rd_im <= mem_im[{rd_bank, rd_addr}];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bank_state[0] <= BANK_FILL;
      bank_state[1] <= BANK_FILL;
      wr_bank       <= 1'b0;
      wr_ptr        <= '0;
      rd_bank       <= 1'b0;
      rd_ptr        <= '0;
      rd_valid      <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_busy;  // data lands with the read register

      if (wr_valid)
        wr_ptr <= wr_ptr + 1'b1;  // wraps into the next bank
      if (wr_done)
      begin
        bank_state[wr_bank] <= BANK_FULL;
        wr_bank             <= ~wr_bank;
      end

      if (rd_busy)
        rd_ptr <= rd_ptr + 1'b1;
      if (rd_done)
      begin
        bank_state[rd_bank] <= BANK_FILL;  // free for the writer again
        rd_bank             <= ~rd_bank;
      end

      // reader idle or finishing, start on a full bank
      // a bank filling this cycle still reads FILL here, so no early start
      if ((!rd_busy || rd_done) && (bank_state[nxt_bank] == BANK_FULL))
        bank_state[nxt_bank] <= BANK_DRAIN;
    end
  end

endmodule

// ==== rtl/fft2d_top.sv ====
`timescale 1ns/1ps

module fft2d_top
  import fft2d_pkg::*;
#(
  parameter int SAMPLE_W = 16
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                in_valid,
  input  logic signed [SAMPLE_W-1:0]          in_data,
  output logic                                out_valid,
  output logic                                out_last,
  output logic signed [SAMPLE_W+2*GROWTH_W-1:0] out_re,
  output logic signed [SAMPLE_W+2*GROWTH_W-1:0] out_im
);

  localparam int ROW_W = SAMPLE_W + GROWTH_W;  // after row transform
  localparam int COL_W = ROW_W + GROWTH_W;     // after column transform

  logic                    row_valid;
  logic signed [ROW_W-1:0] row_re;
  logic signed [ROW_W-1:0] row_im;
  logic                    turn_valid;
  logic signed [ROW_W-1:0] turn_re;
  logic signed [ROW_W-1:0] turn_im;
  logic                    col_valid;
  logic signed [COL_W-1:0] col_re;
  logic signed [COL_W-1:0] col_im;
  logic [FRAME_W-1:0]      out_cnt;  // position of next output in frame

  dft4_stage #(.IN_W(SAMPLE_W)) row_fft_i (
    .clk(clk), .reset(reset), .in_valid(in_valid),
    .in_re(in_data), .in_im('0),  // real input only
    .out_valid(row_valid), .out_re(row_re), .out_im(row_im)
  );

  corner_turn #(.DATA_W(ROW_W)) turn_i (
    .clk(clk), .reset(reset), .wr_valid(row_valid), .wr_re(row_re), .wr_im(row_im),
    .rd_valid(turn_valid), .rd_re(turn_re), .rd_im(turn_im)
  );

  dft4_stage #(.IN_W(ROW_W)) col_fft_i (
    .clk(clk), .reset(reset), .in_valid(turn_valid), .in_re(turn_re), .in_im(turn_im),
    .out_valid(col_valid), .out_re(col_re), .out_im(col_im)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_cnt   <= '0;
    end
    else
    begin
      out_valid <= col_valid;
      out_last  <= col_valid && (out_cnt == FRAME_W'(FRAME_LEN - 1));  // 16th
      if (col_valid)
        out_cnt <= out_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (col_valid)
    begin
      out_re <= col_re;
      out_im <= col_im;
    end
  end

endmodule

// ==== tests/fft2d_props.sv ====
`timescale 1ns/1ps

module fft2d_props
  import fft2d_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic out_valid,
  input logic out_last
);

  logic [FRAME_W:0]   in_cnt;        // strobes taken, stops at one frame
  logic [FRAME_W-1:0] out_pos;       // slot of the current output in its frame
  int                 fail_cnt = 0;  // failed protocol checks

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      in_cnt  <= '0;
      out_pos <= '0;
    end
    else
    begin
      if (in_valid && in_cnt != (FRAME_W+1)'(FRAME_LEN))
        in_cnt <= in_cnt + 1'b1;
      if (out_valid)
        out_pos <= out_pos + 1'b1;  // wraps every frame
    end
  end

  // nothing may come out before the first frame is complete
  assert property (@(posedge clk) disable iff (reset)
    (in_cnt != (FRAME_W+1)'(FRAME_LEN)) |-> !out_valid)
    else
    begin
      fail_cnt++;
      $error("out_valid rose before sixteen samples were taken");
    end

  assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
    else
    begin
      fail_cnt++;
      $error("out_last high without out_valid");
    end

  assert property (@(posedge clk) disable iff (reset)
    out_valid |-> (out_last == (out_pos == FRAME_W'(FRAME_LEN - 1))))
    else
    begin
      fail_cnt++;
      $error("out_last not on the sixteenth output of a frame");
    end

  // a frame leaves as one burst
  assert property (@(posedge clk) disable iff (reset) (out_valid && !out_last) |=> out_valid)
    else
    begin
      fail_cnt++;
      $error("gap inside an output frame");
    end

  assert property (@(posedge clk) disable iff (reset) !$isunknown({out_valid, out_last}))
    else
    begin
      fail_cnt++;
      $error("out_valid or out_last unknown after reset");
    end

endmodule

bind fft2d_top fft2d_props props_i (
  .clk(clk), .reset(reset), .in_valid(in_valid), .out_valid(out_valid), .out_last(out_last)
);

// ==== tests/fft2d_tb.sv ====
`timescale 1ns/1ps

module fft2d_tb
  import fft2d_pkg::*;
();

  localparam int SAMPLE_W        = 16;
  localparam int OUT_W           = SAMPLE_W + 2 * GROWTH_W;
  localparam int CLK_PERIOD      = 4;
  localparam int RAND_FRAMES     = 8;                             // back to back
  localparam int GAP_FRAMES      = 6;                             // random idle cycles
  localparam int NUM_FRAMES      = RAND_FRAMES + 1 + GAP_FRAMES;  // plus one constant frame
  localparam int TOTAL_SAMPLES   = NUM_FRAMES * FRAME_LEN;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 4 + 200;

  logic                       clk;
  logic                       reset;
  logic                       in_valid;
  logic signed [SAMPLE_W-1:0] in_data;
  logic                       out_valid;
  logic                       out_last;
  logic signed [OUT_W-1:0]    out_re;
  logic signed [OUT_W-1:0]    out_im;

  logic [15:0] lfsr = 16'd44;     // seed
  int          frame_x [FRAME_LEN];  // current frame, row-major
  int          exp_re_q [$];      // expected outputs in arrival order
  int          exp_im_q [$];
  int          head_re = 0;       // queue head, refreshed on the falling edge
  int          head_im = 0;
  bit          have_head = 1'b0;
  bit          prev_valid = 1'b0;  // out_valid seen in the last cycle
  int          got_re;
  int          got_im;
  int          out_count = 0;
  int          frames_sent = 0;
  int          errors = 0;
  int          total_errors;

  fft2d_top #(.SAMPLE_W(SAMPLE_W)) dut_i (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_data(in_data),
    .out_valid(out_valid), .out_last(out_last), .out_re(out_re), .out_im(out_im)
  );

  assign got_re = int'(out_re);  // sign extended
  assign got_im = int'(out_im);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = lfsr_next(lfsr);  // one step per bit
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  // multiply by W^m with W = -j, real part
  function automatic int rot_re(input int re, input int im, input int m);
    case (m % 4)
      0:       return re;
      1:       return im;   // times -j
      2:       return -re;
      default: return -im;  // times +j
    endcase
  endfunction

  // same, imaginary part
  function automatic int rot_im(input int re, input int im, input int m);
    case (m % 4)
      0:       return im;
      1:       return -re;
      2:       return -im;
      default: return re;
    endcase
  endfunction

  // direct 2-D DFT of frame_x, rows first, pushed u outer / v inner
  task automatic push_reference();
    int y_re [N_PT][N_PT];
    int y_im [N_PT][N_PT];
    int z_re;
    int z_im;
    for (int r = 0; r < N_PT; r++)
      for (int k = 0; k < N_PT; k++)
      begin
        y_re[r][k] = 0;
        y_im[r][k] = 0;
        for (int c = 0; c < N_PT; c++)
        begin
          y_re[r][k] += rot_re(frame_x[r*N_PT+c], 0, k * c);
          y_im[r][k] += rot_im(frame_x[r*N_PT+c], 0, k * c);
        end
      end
    for (int u = 0; u < N_PT; u++)
      for (int v = 0; v < N_PT; v++)
      begin
        z_re = 0;
        z_im = 0;
        for (int r = 0; r < N_PT; r++)
        begin
          z_re += rot_re(y_re[r][u], y_im[r][u], v * r);
          z_im += rot_im(y_re[r][u], y_im[r][u], v * r);
        end
        exp_re_q.push_back(z_re);
        exp_im_q.push_back(z_im);
      end
  endtask

  task automatic send_frame(input bit with_gaps, input bit constant, input int level);
    int value;
    int gap;
    for (int i = 0; i < FRAME_LEN; i++)
    begin
      if (constant)
        value = level;
      else
      begin
        draw_bits(SAMPLE_W, value);
        value = int'($signed(SAMPLE_W'(value)));  // two's complement sample
      end
      frame_x[i] = value;
      @(negedge clk);
      in_valid = 1'b1;
      in_data  = SAMPLE_W'(value);
      if (with_gaps)
      begin
        draw_bits(2, gap);  // 0 to 3 idle cycles
        repeat (gap)
        begin
          @(negedge clk);
          in_valid = 1'b0;
        end
      end
    end
    push_reference();
    frames_sent++;
  endtask

  // consume the entry checked at the last rising edge, then expose the next one
  always @(negedge clk)
  begin
    if (prev_valid)
    begin
      out_count++;
      if (exp_re_q.size() > 0)
      begin
        void'(exp_re_q.pop_front());
        void'(exp_im_q.pop_front());
      end
    end
    prev_valid = (out_valid === 1'b1);
    have_head  = (exp_re_q.size() > 0);
    if (have_head)
    begin
      head_re = exp_re_q[0];
      head_im = exp_im_q[0];
    end
  end

  assert property (@(posedge clk) disable iff (reset) out_valid |-> have_head)
    else
    begin
      errors++;
      $display("output at %0t arrived with no expected value pending", $time);
    end

  assert property (@(posedge clk) disable iff (reset)
    (out_valid && have_head) |-> (got_re == head_re && got_im == head_im))
    else
    begin
      errors++;
      $display("mismatch at %0t: expected (%0d, %0d), got (%0d, %0d)",
               $time, $sampled(head_re), $sampled(head_im),
               $sampled(got_re), $sampled(got_im));
    end

  initial
  begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int f = 0; f < RAND_FRAMES; f++)
      send_frame(1'b0, 1'b0, 0);
    send_frame(1'b0, 1'b1, -1234);  // dc only, bin 0 gets 16x
    @(negedge clk);
    in_valid = 1'b0;
    repeat (5) @(negedge clk);

    for (int f = 0; f < GAP_FRAMES; f++)
      send_frame(1'b1, 1'b0, 0);
    @(negedge clk);
    in_valid = 1'b0;

    while (exp_re_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);  // catch any stray output

    assert (out_count == FRAME_LEN * frames_sent)
    else
    begin
      errors++;
      $display("mismatch at %0t: %0d outputs for %0d frames, expected %0d",
               $time, out_count, frames_sent, FRAME_LEN * frames_sent);
    end

    total_errors = errors + dut_i.props_i.fail_cnt;
    $display("errors: %0d value/count, %0d protocol; %0d outputs, %0d frames",
             errors, dut_i.props_i.fail_cnt, out_count, frames_sent);
    if (total_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles with %0d outputs pending",
             WATCHDOG_CYCLES, exp_re_q.size());
    $display("test failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/fft2d_pkg.sv
rtl/dft4_stage.sv
rtl/corner_turn.sv
rtl/fft2d_top.sv
tests/fft2d_props.sv
tests/fft2d_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the 2-D FFT testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=fft2d_sim

verilator --binary --timing --assert -f vlog.f --top-module fft2d_tb -o "$SIM"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench gives its own verdict
./obj_dir/"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
